// ==== hdl/drive_io_pkg.sv ====
/*
 * Shared constants and types for the drive-side glue.
 * Imported by the interfaces and the RTL modules that need them.
 */

package drive_io_pkg;

	// ========================================================================
	// Sector buffer and image fields
	// ========================================================================

	// 512-byte sector buffer
	localparam int BUF_ADDR_W = 9;

	// Image type as reported to the controller
	localparam int FILE_TYPE_W = 2;

	// Slots 4 and 5 always report read-only, one bit per slot
	localparam logic [7:0] FORCED_RO_SLOTS = 8'b0011_0000;

	// ========================================================================
	// Mouse
	// ========================================================================

	// Signed delta and axis accumulator width
	localparam int MOUSE_DELTA_W = 9;

	// Controller data-out word, read as an LBA or as a buffer byte
	typedef union packed {
		logic [31:0] lba;
		struct packed {
			logic [23:0] unused;
			logic [7:0]  value;
		} data;
	} ctrl_data_t;

endpackage

// ==== hdl/drive_io_intf.sv ====
/*
 * Interfaces between the RTL modules of the drive glue.
 * buf_port_if carries the controller side of the sector RAM,
 * mount_status_if carries the latched image mount fields.
 */

`timescale 1ns/1ps

interface buf_port_if;
	import drive_io_pkg::*;

	// Controller side of the sector RAM
	logic [BUF_ADDR_W-1:0] addr;
	logic [7:0]            wdata;
	logic                  we;
	// Registered read, valid one cycle after addr
	logic [7:0]            rdata;

	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	modport ram (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);
endinterface

interface mount_status_if #(
	parameter int NUM_DRIVES = 8
);
	import drive_io_pkg::*;

	localparam int SLOT_W = $clog2(NUM_DRIVES);

	// Toggles on every new mount
	logic                   mounted;
	logic [SLOT_W-1:0]      slot;
	logic [FILE_TYPE_W-1:0] file_type;
	logic                   read_only;
	logic [31:0]            file_size;

	modport regs (
		output mounted,
		output slot,
		output file_type,
		output read_only,
		output file_size
	);

	modport ctrl (
		input mounted,
		input slot,
		input file_type,
		input read_only,
		input file_size
	);
endinterface

// ==== hdl/sector_buffer.sv ====
/*
 * 512 x 8 true dual-port sector RAM.
 * Port A belongs to the host sector interface, port B to the drive
 * controller. Both ports have registered reads.
 */

`timescale 1ns/1ps

module sector_buffer (
	input  logic                              clk_sys,
	input  logic [drive_io_pkg::BUF_ADDR_W-1:0] sd_buff_addr_i,
	input  logic [7:0]                        sd_buff_dout_i,
	input  logic                              sd_buff_wr_i,
	output logic [7:0]                        sd_buff_din_o,
	buf_port_if.ram                           buf_port
);
	import drive_io_pkg::*;

	localparam int DEPTH = 1 << BUF_ADDR_W;

	logic [7:0] mem [DEPTH];

	// Power-up contents for simulation
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 8'h00;
		end
	end

	// Host port first, controller port second on a same-address write
	always @(posedge clk_sys) begin
		if (sd_buff_wr_i) begin
			mem[sd_buff_addr_i] <= sd_buff_dout_i;
		end
		sd_buff_din_o <= mem[sd_buff_addr_i];

		if (buf_port.we) begin
			mem[buf_port.addr] <= buf_port.wdata;
		end
		buf_port.rdata <= mem[buf_port.addr];
	end

endmodule

// ==== hdl/image_mount_regs.sv ====
/*
 * Latches the fields of a freshly mounted disk image.
 * A rising edge on any img_mounted_i bit captures slot, type, size and
 * read-only state, and toggles the mounted flag seen by the controller.
 */

`timescale 1ns/1ps

module image_mount_regs #(
	parameter int NUM_DRIVES = 8
) (
	input  logic                               clk_sys,
	input  logic                               areset,
	input  logic [NUM_DRIVES-1:0]              img_mounted_i,
	input  logic                               img_readonly_i,
	input  logic [31:0]                        img_size_i,
	input  logic [drive_io_pkg::FILE_TYPE_W-1:0] img_type_i,
	mount_status_if.regs                       mount
);
	import drive_io_pkg::*;

	localparam int SLOT_W = $clog2(NUM_DRIVES);

	logic              mnt_any;
	logic              mnt_d1;
	logic              mnt_rise;
	logic [SLOT_W-1:0] slot_next;
	logic              forced_ro;

	assign mnt_any  = |img_mounted_i;
	assign mnt_rise = mnt_any && !mnt_d1;

	// Highest set bit wins when several slots report at once
	always_comb begin
		slot_next = '0;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (img_mounted_i[i]) begin
				slot_next = SLOT_W'(i);
			end
		end
	end

	assign forced_ro = FORCED_RO_SLOTS[3'(slot_next)];

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mnt_d1        <= 1'b0;
			mount.mounted <= 1'b0;
		end else begin
			mnt_d1 <= mnt_any;
			if (mnt_rise) begin
				mount.mounted <= !mount.mounted;
			end
		end
	end

	// Mount fields, valid once mounted has toggled
	always_ff @(posedge clk_sys) begin
		if (mnt_rise) begin
			mount.slot      <= slot_next;
			mount.file_type <= img_type_i;
			mount.read_only <= img_readonly_i | forced_ro;
			mount.file_size <= img_size_i;
		end
	end

endmodule

// ==== hdl/block_request_ctrl.sv ====
/*
 * Bridge between the drive controller register ports and the host
 * sector interface. Handles LBA latching, the sector buffer pointer,
 * per-drive read and write requests and the io-done flag.
 */

`timescale 1ns/1ps

module block_request_ctrl #(
	parameter int NUM_DRIVES = 8
) (
	input  logic                      clk_sys,
	input  logic                      areset,
	input  logic [31:0]               ctrl_out2_i,
	input  drive_io_pkg::ctrl_data_t  ctrl_out3_i,
	input  logic [15:0]               ctrl_wr_i,
	input  logic [15:0]               ctrl_rd_i,
	input  logic [NUM_DRIVES-1:0]     sd_ack_i,
	output logic [31:0]               sd_lba_o,
	output logic [NUM_DRIVES-1:0]     sd_rd_o,
	output logic [NUM_DRIVES-1:0]     sd_wr_o,
	output logic [7:0]                ctrl_in2_o,
	output logic [31:0]               ctrl_in3_o,
	buf_port_if.ctrl                  buf_port,
	mount_status_if.ctrl              mount
);
	import drive_io_pkg::*;

	localparam int SLOT_W = $clog2(NUM_DRIVES);

	// ========================================================================
	// Controller register decode
	// ========================================================================

	logic              lba_sel;
	logic              block_rd;
	logic              block_wr;
	logic [SLOT_W-1:0] drv_num;
	logic              io_wr;
	logic              data_wr;
	logic              data_rd;

	assign lba_sel  = ctrl_out2_i[0];
	assign block_rd = ctrl_out2_i[1];
	assign block_wr = ctrl_out2_i[2];
	assign drv_num  = ctrl_out2_i[3 +: SLOT_W];
	assign io_wr    = ctrl_wr_i[5];
	assign data_wr  = ctrl_wr_i[6];
	assign data_rd  = ctrl_rd_i[2];

	logic [BUF_ADDR_W-1:0] ptr;
	logic                  buf_wr;
	logic                  wr_d1;
	logic                  wr_d2;
	logic                  wr_rise;
	logic                  rd_d1;
	logic                  blrd_d1;
	logic                  blwr_d1;
	logic                  ack_any;
	logic                  ack_d1;
	logic                  io_done;

	// Data-write strobe is seen through two flops
	assign wr_rise = wr_d1 && !wr_d2;
	assign ack_any = |sd_ack_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr     <= '0;
			buf_wr  <= 1'b0;
			wr_d1   <= 1'b0;
			wr_d2   <= 1'b0;
			rd_d1   <= 1'b0;
			blrd_d1 <= 1'b0;
			blwr_d1 <= 1'b0;
			ack_d1  <= 1'b0;
			io_done <= 1'b1;
			sd_rd_o <= '0;
			sd_wr_o <= '0;
		end else begin
			// Pointer moves the edge after the byte is stored
			buf_wr <= 1'b0;
			if (buf_wr) begin
				ptr <= ptr + BUF_ADDR_W'(1);
			end

			wr_d1 <= data_wr;
			wr_d2 <= wr_d1;
			if (wr_rise && !lba_sel) begin
				buf_wr <= 1'b1;
			end

			// Read strobe advances on its falling edge
			rd_d1 <= data_rd;
			if (rd_d1 && !data_rd) begin
				ptr <= ptr + BUF_ADDR_W'(1);
			end

			if (io_wr) begin
				ptr <= '0;
			end

			blrd_d1 <= block_rd;
			if (block_rd && !blrd_d1) begin
				io_done          <= 1'b0;
				sd_rd_o[drv_num] <= 1'b1;
			end

			blwr_d1 <= block_wr;
			if (block_wr && !blwr_d1) begin
				io_done          <= 1'b0;
				sd_wr_o[drv_num] <= 1'b1;
			end

			// Host acknowledge drops every pending request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end

			ack_d1 <= ack_any;
			if (ack_d1 && !ack_any) begin
				io_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise && lba_sel) begin
			sd_lba_o <= ctrl_out3_i.lba;
		end
	end

	// ========================================================================
	// Buffer port and readback
	// ========================================================================

	assign buf_port.addr  = ptr;
	assign buf_port.wdata = ctrl_out3_i.data.value;
	assign buf_port.we    = buf_wr;

	assign ctrl_in2_o = {mount.read_only, mount.file_type, 3'(mount.slot), mount.mounted, io_done};
	assign ctrl_in3_o = lba_sel ? mount.file_size : {24'h000000, buf_port.rdata};

endmodule

// ==== hdl/mouse_axis_emu.sv ====
/*
 * PS/2 mouse to paddle emulation.
 * Mouse reports build up two clamped analog axes; any stick movement or
 * a CPU halt hands the axes back to the real analog stick.
 */

`timescale 1ns/1ps

module mouse_axis_emu #(
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic        clk_sys,
	input  logic        areset,
	input  logic [24:0] ps2_mouse_i,
	input  logic [15:0] joya_i,
	input  logic [1:0]  joy_btn_i,
	input  logic        invert_y_i,
	input  logic        cpu_halt_i,
	output logic [7:0]  axis_x_o,
	output logic [7:0]  axis_y_o,
	output logic [1:0]  fire_o
);
	import drive_io_pkg::*;

	localparam logic signed [MOUSE_DELTA_W-1:0] STEP_POS = MOUSE_DELTA_W'(MOUSE_STEP_MAX);
	localparam logic signed [MOUSE_DELTA_W-1:0] STEP_NEG = -STEP_POS;
	localparam logic signed [MOUSE_DELTA_W-1:0] AXIS_MAX = MOUSE_DELTA_W'(127);
	localparam logic signed [MOUSE_DELTA_W-1:0] AXIS_MIN = -MOUSE_DELTA_W'(128);

	logic                             mouse_on;
	logic                             stb_d1;
	logic signed [MOUSE_DELTA_W-1:0]  mx;
	logic signed [MOUSE_DELTA_W-1:0]  my;
	logic signed [MOUSE_DELTA_W-1:0]  dx;
	logic signed [MOUSE_DELTA_W-1:0]  dy;
	logic signed [MOUSE_DELTA_W-1:0]  dx_clamp;
	logic signed [MOUSE_DELTA_W-1:0]  dy_clamp;
	logic signed [MOUSE_DELTA_W-1:0]  mx_next;
	logic signed [MOUSE_DELTA_W-1:0]  my_next;

	// Delta is sign bit plus the upper seven bits, so half speed
	assign dx = {ps2_mouse_i[4], ps2_mouse_i[4], ps2_mouse_i[15:9]};
	assign dy = {ps2_mouse_i[5], ps2_mouse_i[5], ps2_mouse_i[23:17]};

	assign dx_clamp = (dx > STEP_POS) ? STEP_POS : (dx < STEP_NEG) ? STEP_NEG : dx;
	assign dy_clamp = (dy > STEP_POS) ? STEP_POS : (dy < STEP_NEG) ? STEP_NEG : dy;

	assign mx_next = mx + dx_clamp;
	assign my_next = invert_y_i ? (my - dy_clamp) : (my + dy_clamp);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_d1   <= 1'b0;
			mouse_on <= 1'b0;
			mx       <= '0;
			my       <= '0;
		end else begin
			stb_d1 <= ps2_mouse_i[24];
			// New report whenever the strobe bit flips
			if (stb_d1 != ps2_mouse_i[24]) begin
				mouse_on <= 1'b1;
				mx <= (mx_next < AXIS_MIN) ? AXIS_MIN : (mx_next > AXIS_MAX) ? AXIS_MAX : mx_next;
				my <= (my_next < AXIS_MIN) ? AXIS_MIN : (my_next > AXIS_MAX) ? AXIS_MAX : my_next;
			end

			// Real stick or halted CPU takes over
			if ((|joya_i) || cpu_halt_i) begin
				mouse_on <= 1'b0;
				mx       <= '0;
				my       <= '0;
			end
		end
	end

	assign axis_x_o = mouse_on ? mx[7:0] : joya_i[7:0];
	assign axis_y_o = mouse_on ? my[7:0] : joya_i[15:8];
	assign fire_o   = mouse_on ? ps2_mouse_i[1:0] : joy_btn_i;

endmodule

// ==== hdl/drive_io_top.sv ====
/*
 * Top level of the drive-side glue and mouse paddle logic.
 * Connects the request controller, mount registers, sector buffer and
 * mouse emulation; the drive count is set here and passed down.
 */

`timescale 1ns/1ps

module drive_io_top #(
	parameter int NUM_DRIVES     = 8,
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	input  logic [31:0]                          ctrl_out2_i,
	input  logic [31:0]                          ctrl_out3_i,
	input  logic [15:0]                          ctrl_wr_i,
	input  logic [15:0]                          ctrl_rd_i,
	output logic [7:0]                           ctrl_in2_o,
	output logic [31:0]                          ctrl_in3_o,
	input  logic [NUM_DRIVES-1:0]                sd_ack_i,
	input  logic [drive_io_pkg::BUF_ADDR_W-1:0]  sd_buff_addr_i,
	input  logic [7:0]                           sd_buff_dout_i,
	input  logic                                 sd_buff_wr_i,
	output logic [31:0]                          sd_lba_o,
	output logic [NUM_DRIVES-1:0]                sd_rd_o,
	output logic [NUM_DRIVES-1:0]                sd_wr_o,
	output logic [7:0]                           sd_buff_din_o,
	input  logic [NUM_DRIVES-1:0]                img_mounted_i,
	input  logic                                 img_readonly_i,
	input  logic [31:0]                          img_size_i,
	input  logic [drive_io_pkg::FILE_TYPE_W-1:0] img_type_i,
	input  logic [24:0]                          ps2_mouse_i,
	input  logic [15:0]                          joya_i,
	input  logic [1:0]                           joy_btn_i,
	input  logic                                 invert_y_i,
	input  logic                                 cpu_halt_i,
	output logic [7:0]                           axis_x_o,
	output logic [7:0]                           axis_y_o,
	output logic [1:0]                           fire_o
);

	buf_port_if                                 buf_port ();
	mount_status_if #(.NUM_DRIVES(NUM_DRIVES)) mount_status ();

	block_request_ctrl #(.NUM_DRIVES(NUM_DRIVES)) block_request_ctrl_inst (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.ctrl_out2_i (ctrl_out2_i),
		.ctrl_out3_i (ctrl_out3_i),
		.ctrl_wr_i   (ctrl_wr_i),
		.ctrl_rd_i   (ctrl_rd_i),
		.sd_ack_i    (sd_ack_i),
		.sd_lba_o    (sd_lba_o),
		.sd_rd_o     (sd_rd_o),
		.sd_wr_o     (sd_wr_o),
		.ctrl_in2_o  (ctrl_in2_o),
		.ctrl_in3_o  (ctrl_in3_o),
		.buf_port    (buf_port.ctrl),
		.mount       (mount_status.ctrl)
	);

	// Mount registers steer the status fields read by the controller
	image_mount_regs #(.NUM_DRIVES(NUM_DRIVES)) image_mount_regs_inst (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.mount          (mount_status.regs)
	);

	sector_buffer sector_buffer_inst (
		.clk_sys        (clk_sys),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_din_o  (sd_buff_din_o),
		.buf_port       (buf_port.ram)
	);

	mouse_axis_emu #(.MOUSE_STEP_MAX(MOUSE_STEP_MAX)) mouse_axis_emu_inst (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.ps2_mouse_i (ps2_mouse_i),
		.joya_i      (joya_i),
		.joy_btn_i   (joy_btn_i),
		.invert_y_i  (invert_y_i),
		.cpu_halt_i  (cpu_halt_i),
		.axis_x_o    (axis_x_o),
		.axis_y_o    (axis_y_o),
		.fire_o      (fire_o)
	);

endmodule

// ==== testbench/drive_io_sva.sv ====
/*
 * Protocol assertions for the block request controller.
 * Bound into every block_request_ctrl instance by the bind below.
 */

`timescale 1ns/1ps

module drive_io_sva #(
	parameter int NUM_DRIVES = 8
) (
	input logic                          clk_sys,
	input logic                          areset,
	input logic [$clog2(NUM_DRIVES)-1:0] drv_num,
	input logic [NUM_DRIVES-1:0]         sd_ack_i,
	input logic [NUM_DRIVES-1:0]         sd_rd_o,
	input logic [NUM_DRIVES-1:0]         sd_wr_o,
	input logic                          io_done
);
	logic [NUM_DRIVES-1:0] req_all;

	assign req_all = sd_rd_o | sd_wr_o;

	// New request bits only at the drive number given with the strobe
	new_req_single: assert property (@(posedge clk_sys) disable iff (areset)
		(req_all & ~$past(req_all) & ~(NUM_DRIVES'(1) << $past(drv_num))) == '0)
		else $error("request bit set outside the addressed drive in one cycle");

	// Any acknowledge drops every request on the next edge
	ack_clears_req: assert property (@(posedge clk_sys) disable iff (areset)
		(|sd_ack_i) |=> (req_all == '0))
		else $error("request still pending after acknowledge");

	pending_not_done: assert property (@(posedge clk_sys) disable iff (areset)
		(|req_all) |-> !io_done)
		else $error("io-done high while a request is pending");

endmodule

bind block_request_ctrl drive_io_sva #(.NUM_DRIVES(NUM_DRIVES)) drive_io_sva_inst (
	.clk_sys  (clk_sys),
	.areset   (areset),
	.drv_num  (drv_num),
	.sd_ack_i (sd_ack_i),
	.sd_rd_o  (sd_rd_o),
	.sd_wr_o  (sd_wr_o),
	.io_done  (io_done)
);

// ==== testbench/tb_drive_io.sv ====
/*
 * Testbench for the drive glue top level.
 * Random stimulus from a fixed seed, checked against a reference model of
 * the buffer pointer, sector buffer, LBA, requests, mounts and mouse axes.
 */

`timescale 1ns/1ps

module tb_drive_io;

	localparam int NUM_DRIVES  = 8;
	localparam int STEP_MAX    = 10;
	localparam int NUM_BYTES   = 16;
	localparam int TEST_CYCLES = 520;
	localparam int CYCLE_LIMIT = TEST_CYCLES * 2 + 200;

	logic        clk_sys = 1'b0;
	logic        areset;
	logic [31:0] ctrl_out2_i;
	logic [31:0] ctrl_out3_i;
	logic [15:0] ctrl_wr_i;
	logic [15:0] ctrl_rd_i;
	logic [7:0]  ctrl_in2_o;
	logic [31:0] ctrl_in3_o;
	logic [7:0]  sd_ack_i;
	logic [8:0]  sd_buff_addr_i;
	logic [7:0]  sd_buff_dout_i;
	logic        sd_buff_wr_i;
	logic [31:0] sd_lba_o;
	logic [7:0]  sd_rd_o;
	logic [7:0]  sd_wr_o;
	logic [7:0]  sd_buff_din_o;
	logic [7:0]  img_mounted_i;
	logic        img_readonly_i;
	logic [31:0] img_size_i;
	logic [1:0]  img_type_i;
	logic [24:0] ps2_mouse_i;
	logic [15:0] joya_i;
	logic [1:0]  joy_btn_i;
	logic        invert_y_i;
	logic        cpu_halt_i;
	logic [7:0]  axis_x_o;
	logic [7:0]  axis_y_o;
	logic [1:0]  fire_o;

	int error_count = 0;
	int cycle_count = 0;

	// Reference model state
	logic [7:0]  buf_model [512];
	logic [8:0]  ptr_model;
	logic [31:0] lba_model;
	logic        mounted_model;
	int          mx_model;
	int          my_model;
	logic        mouse_stb;

	drive_io_top #(
		.NUM_DRIVES     (NUM_DRIVES),
		.MOUSE_STEP_MAX (STEP_MAX)
	) drive_io_top_inst (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctrl_out2_i    (ctrl_out2_i),
		.ctrl_out3_i    (ctrl_out3_i),
		.ctrl_wr_i      (ctrl_wr_i),
		.ctrl_rd_i      (ctrl_rd_i),
		.ctrl_in2_o     (ctrl_in2_o),
		.ctrl_in3_o     (ctrl_in3_o),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_buff_din_o  (sd_buff_din_o),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.ps2_mouse_i    (ps2_mouse_i),
		.joya_i         (joya_i),
		.joy_btn_i      (joy_btn_i),
		.invert_y_i     (invert_y_i),
		.cpu_halt_i     (cpu_halt_i),
		.axis_x_o       (axis_x_o),
		.axis_y_o       (axis_y_o),
		.fire_o         (fire_o)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout, run did not finish within %0d cycles, %0d errors",
				CYCLE_LIMIT, error_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		error_count++;
		$display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// Data-write strobe, lands two edges after it rises
	task automatic ctrl_data_write(input logic lba, input logic [31:0] word);
		@(posedge clk_sys);
		ctrl_out2_i <= {31'd0, lba};
		ctrl_out3_i <= word;
		ctrl_wr_i   <= 16'h0040;
		wait_cycles(3);
		ctrl_wr_i <= 16'h0000;
		wait_cycles(2);
		if (lba) begin
			lba_model = word;
		end else begin
			buf_model[ptr_model] = word[7:0];
			ptr_model = ptr_model + 9'd1;
		end
	endtask

	// io-write pulse clears the pointer, then one edge for the stale read
	task automatic pointer_reset();
		@(posedge clk_sys);
		ctrl_wr_i <= 16'h0020;
		@(posedge clk_sys);
		ctrl_wr_i <= 16'h0000;
		@(posedge clk_sys);
		ptr_model = 9'd0;
	endtask

	task automatic data_read_pulse();
		@(posedge clk_sys);
		ctrl_rd_i <= 16'h0004;
		wait_cycles(2);
		ctrl_rd_i <= 16'h0000;
		wait_cycles(2);
		ptr_model = ptr_model + 9'd1;
	endtask

	task automatic host_write(input logic [8:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		sd_buff_wr_i   <= 1'b1;
		sd_buff_addr_i <= addr;
		sd_buff_dout_i <= data;
		@(posedge clk_sys);
		sd_buff_wr_i <= 1'b0;
		buf_model[addr] = data;
	endtask

	task automatic host_read_check(input logic [8:0] addr);
		@(posedge clk_sys);
		sd_buff_addr_i <= addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (sd_buff_din_o !== buf_model[addr]) begin
			report_mismatch("sd_buff_din_o", 32'(sd_buff_din_o), 32'(buf_model[addr]));
		end
	endtask

	task automatic block_request(input logic [2:0] drv, input logic is_write);
		logic [7:0] req_bit;
		logic [7:0] rd_exp;
		logic [7:0] wr_exp;
		req_bit = 8'(1) << drv;
		rd_exp  = is_write ? 8'd0 : req_bit;
		wr_exp  = is_write ? req_bit : 8'd0;
		@(posedge clk_sys);
		ctrl_out2_i <= {26'd0, drv, is_write, !is_write, 1'b0};
		wait_cycles(2);
		ctrl_out2_i <= 32'd0;
		@(negedge clk_sys);
		if (sd_rd_o !== rd_exp) begin
			report_mismatch("sd_rd_o", 32'(sd_rd_o), 32'(rd_exp));
		end
		if (sd_wr_o !== wr_exp) begin
			report_mismatch("sd_wr_o", 32'(sd_wr_o), 32'(wr_exp));
		end
		if (ctrl_in2_o[0] !== 1'b0) begin
			report_mismatch("ctrl_in2_o[0]", 32'(ctrl_in2_o[0]), 32'd0);
		end
		// Acknowledge, then release it
		@(posedge clk_sys);
		sd_ack_i <= req_bit;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if ((sd_rd_o | sd_wr_o) !== 8'd0) begin
			report_mismatch("sd_rd_o|sd_wr_o", 32'(sd_rd_o | sd_wr_o), 32'd0);
		end
		if (ctrl_in2_o[0] !== 1'b0) begin
			report_mismatch("ctrl_in2_o[0]", 32'(ctrl_in2_o[0]), 32'd0);
		end
		@(posedge clk_sys);
		sd_ack_i <= 8'd0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (ctrl_in2_o[0] !== 1'b1) begin
			report_mismatch("ctrl_in2_o[0]", 32'(ctrl_in2_o[0]), 32'd1);
		end
	endtask

	task automatic mount_image(input logic [2:0] slot, input logic ro);
		logic [1:0]  typ;
		logic [31:0] size;
		logic        ro_exp;
		logic [7:0]  status_exp;
		typ    = 2'($urandom);
		size   = $urandom;
		ro_exp = ro || (slot == 3'd4) || (slot == 3'd5);
		mounted_model = !mounted_model;
		status_exp = {ro_exp, typ, slot, mounted_model, 1'b1};
		@(posedge clk_sys);
		img_mounted_i  <= 8'(1) << slot;
		img_type_i     <= typ;
		img_readonly_i <= ro;
		img_size_i     <= size;
		ctrl_out2_i    <= 32'd1;
		wait_cycles(2);
		img_mounted_i <= 8'd0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (ctrl_in2_o !== status_exp) begin
			report_mismatch("ctrl_in2_o", 32'(ctrl_in2_o), 32'(status_exp));
		end
		// LBA-select reads back the image size
		if (ctrl_in3_o !== size) begin
			report_mismatch("ctrl_in3_o", ctrl_in3_o, size);
		end
	endtask

	function automatic int step_clamp(input int d);
		if (d > STEP_MAX) begin
			return STEP_MAX;
		end
		if (d < -STEP_MAX) begin
			return -STEP_MAX;
		end
		return d;
	endfunction

	function automatic int axis_sat(input int v);
		if (v > 127) begin
			return 127;
		end
		if (v < -128) begin
			return -128;
		end
		return v;
	endfunction

	// X leans positive and Y negative so both rails get reached
	task automatic mouse_report(input logic invert);
		logic [7:0] dx_byte;
		logic [7:0] dy_byte;
		logic       sx;
		logic       sy;
		logic [1:0] btn;
		int         dx;
		int         dy;
		dx_byte = 8'($urandom);
		dy_byte = 8'($urandom);
		sx      = ($urandom_range(7) == 0);
		sy      = ($urandom_range(7) != 0);
		btn     = 2'($urandom);
		mouse_stb = !mouse_stb;
		// Delta is the upper seven bits with the sign bit on top
		dx = int'(dx_byte[7:1]);
		dy = int'(dy_byte[7:1]);
		if (sx) begin
			dx = dx - 128;
		end
		if (sy) begin
			dy = dy - 128;
		end
		mx_model = axis_sat(mx_model + step_clamp(dx));
		if (invert) begin
			my_model = axis_sat(my_model - step_clamp(dy));
		end else begin
			my_model = axis_sat(my_model + step_clamp(dy));
		end
		@(posedge clk_sys);
		ps2_mouse_i <= {mouse_stb, dy_byte, dx_byte, 2'b00, sy, sx, 2'b00, btn};
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (axis_x_o !== 8'(mx_model)) begin
			report_mismatch("axis_x_o", 32'(axis_x_o), 32'(8'(mx_model)));
		end
		if (axis_y_o !== 8'(my_model)) begin
			report_mismatch("axis_y_o", 32'(axis_y_o), 32'(8'(my_model)));
		end
		if (fire_o !== btn) begin
			report_mismatch("fire_o", 32'(fire_o), 32'(btn));
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		logic [15:0] stick;
		logic [1:0]  btn;
		void'($urandom(32'hbbe23b17));
		areset         = 1'b1;
		ctrl_out2_i    = 32'd0;
		ctrl_out3_i    = 32'd0;
		ctrl_wr_i      = 16'd0;
		ctrl_rd_i      = 16'd0;
		sd_ack_i       = 8'd0;
		sd_buff_addr_i = 9'd0;
		sd_buff_dout_i = 8'd0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = 8'd0;
		img_readonly_i = 1'b0;
		img_size_i     = 32'd0;
		img_type_i     = 2'd0;
		ps2_mouse_i    = 25'd0;
		joya_i         = 16'd0;
		joy_btn_i      = 2'd0;
		invert_y_i     = 1'b0;
		cpu_halt_i     = 1'b0;
		for (int i = 0; i < 512; i++) begin
			buf_model[i] = 8'h00;
		end
		ptr_model     = 9'd0;
		lba_model     = 32'd0;
		mounted_model = 1'b0;
		mx_model      = 0;
		my_model      = 0;
		mouse_stb     = 1'b0;

		repeat (2) @(posedge clk_sys);
		areset <= 1'b0;
		@(negedge clk_sys);
		// Idle status: io-done set, nothing mounted, no requests
		if (ctrl_in2_o[1:0] !== 2'b01) begin
			report_mismatch("ctrl_in2_o[1:0]", 32'(ctrl_in2_o[1:0]), 32'd1);
		end
		if ((sd_rd_o | sd_wr_o) !== 8'd0) begin
			report_mismatch("sd_rd_o|sd_wr_o", 32'(sd_rd_o | sd_wr_o), 32'd0);
		end

		// LBA latching
		for (int i = 0; i < 4; i++) begin
			ctrl_data_write(1'b1, $urandom);
			@(negedge clk_sys);
			if (sd_lba_o !== lba_model) begin
				report_mismatch("sd_lba_o", sd_lba_o, lba_model);
			end
		end

		// Controller writes, host reads back
		pointer_reset();
		for (int i = 0; i < NUM_BYTES; i++) begin
			ctrl_data_write(1'b0, $urandom);
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			host_read_check(9'(i));
		end

		// Host writes, controller reads back
		@(posedge clk_sys);
		ctrl_out2_i <= 32'd0;
		for (int i = 0; i < NUM_BYTES; i++) begin
			host_write(9'(i), 8'($urandom));
		end
		pointer_reset();
		for (int i = 0; i < NUM_BYTES; i++) begin
			if (i > 0) begin
				data_read_pulse();
			end
			@(negedge clk_sys);
			if (ctrl_in3_o !== {24'd0, buf_model[ptr_model]}) begin
				report_mismatch("ctrl_in3_o", ctrl_in3_o, {24'd0, buf_model[ptr_model]});
			end
		end

		// Block requests on random drives
		for (int i = 0; i < 8; i++) begin
			block_request(3'($urandom_range(7)), 1'($urandom));
		end

		// Mounts, slots 4 and 5 first with the image flag clear
		mount_image(3'd4, 1'b0);
		mount_image(3'd5, 1'b0);
		for (int i = 0; i < 8; i++) begin
			mount_image(3'($urandom_range(7)), 1'($urandom));
		end

		// Mouse axes, then the stick takes over
		for (int i = 0; i < 32; i++) begin
			mouse_report(1'b0);
		end
		stick = 16'($urandom_range(65535, 1));
		btn   = 2'($urandom);
		@(posedge clk_sys);
		joya_i    <= stick;
		joy_btn_i <= btn;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if ({axis_y_o, axis_x_o} !== stick) begin
			report_mismatch("axis_y_o:axis_x_o", 32'({axis_y_o, axis_x_o}), 32'(stick));
		end
		if (fire_o !== btn) begin
			report_mismatch("fire_o", 32'(fire_o), 32'(btn));
		end
		@(posedge clk_sys);
		joya_i     <= 16'd0;
		invert_y_i <= 1'b1;
		mx_model = 0;
		my_model = 0;

		for (int i = 0; i < 32; i++) begin
			mouse_report(1'b1);
		end
		// CPU halt also hands back to the stick
		@(posedge clk_sys);
		cpu_halt_i <= 1'b1;
		@(posedge clk_sys);
		cpu_halt_i <= 1'b0;
		@(negedge clk_sys);
		if ({fire_o, axis_y_o, axis_x_o} !== {btn, 16'd0}) begin
			report_mismatch("fire_o:axes", 32'({fire_o, axis_y_o, axis_x_o}), 32'({btn, 16'd0}));
		end
		mx_model = 0;
		my_model = 0;
		mouse_report(1'b1);

		$display("Run complete after %0d cycles, %0d errors", cycle_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/drive_io_pkg.sv
hdl/drive_io_intf.sv
hdl/sector_buffer.sv
hdl/image_mount_regs.sv
hdl/block_request_ctrl.sv
hdl/mouse_axis_emu.sv
hdl/drive_io_top.sv
testbench/drive_io_sva.sv
testbench/tb_drive_io.sv

// ==== Makefile ====
# Verilator build and run for the drive glue testbench

TOP = tb_drive_io

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^TEST PASS$$" sim.log || (echo "Simulation did not pass, see sim.log"; exit 1)

lint:
	verilator --lint-only --timing --top-module drive_io_top -f sources.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
